//--- cache/cacheController.sv
`timescale 1ns/1ps

// write-through, no-write-allocate cache control
// one CPU access in flight, one memory request at a time
module cacheController (
  input logic clk,
  input logic arstN,
  input logic cpuRe,
  input logic cpuWe,
  input cachePkg::addr_t cpuAddr,
  input cachePkg::word_t cpuWData,
  output cachePkg::word_t cpuRData,
  output logic cpuReady,
  output logic cpuHit,
  output cachePkg::index_t rdIndex,
  output logic fillEn,
  output cachePkg::tag_t fillTag,
  output cachePkg::block_t fillBlock,
  output logic wrEn,
  output cachePkg::offset_t wrOffset,
  output cachePkg::word_t wrWord,
  input logic lineValid,
  input cachePkg::tag_t lineTag,
  input cachePkg::block_t lineBlock,
  memBusIf.requester mem
);

  cachePkg::cacheState_t state;
  cachePkg::cacheState_t nextState;

  // latched request
  cachePkg::addr_t reqAddr;
  cachePkg::word_t reqWData;
  logic reqWrite;

  // address fields of the latched request
  cachePkg::tag_t reqTag;
  cachePkg::index_t reqIndex;
  cachePkg::offset_t reqOffset;

  // response registers
  cachePkg::word_t rData;
  logic hitReg;

  logic lookupHit;

  // pull one word out of a block, word 0 on top
  function automatic cachePkg::word_t pickWord(cachePkg::block_t blk, cachePkg::offset_t off);
    int lsb;
    lsb = (cachePkg::BlockWords - 1 - int'(off)) * cachePkg::WordWidth;
    return blk[lsb +: cachePkg::WordWidth];
  endfunction

  assign reqTag = reqAddr[cachePkg::TagLsb +: cachePkg::TagBits];
  assign reqIndex = reqAddr[cachePkg::IndexLsb +: cachePkg::IndexBits];
  assign reqOffset = reqAddr[cachePkg::OffsetLsb +: cachePkg::OffsetBits];

  // store output belongs to reqIndex once in lookup
  assign lookupHit = lineValid && (lineTag == reqTag);

  // state register
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      state <= cachePkg::CacheIdle;
    else
      state <= nextState;
  end

  // next state
  always_comb
  begin
    nextState = state;
    case (state)
      cachePkg::CacheIdle:
      begin
        if (cpuRe || cpuWe)
          nextState = cachePkg::CacheLookup;
      end
      cachePkg::CacheLookup:
      begin
        // writes always go to memory
        if (reqWrite)
          nextState = cachePkg::CacheWriteThrough;
        else if (lookupHit)
          nextState = cachePkg::CacheRespond;
        else
          nextState = cachePkg::CacheReadMiss;
      end
      cachePkg::CacheReadMiss,
      cachePkg::CacheWriteThrough:
      begin
        if (mem.valid)
          nextState = cachePkg::CacheRespond;
      end
      cachePkg::CacheRespond:
        nextState = cachePkg::CacheIdle;
      default:
        nextState = cachePkg::CacheIdle;
    endcase
  end

  // request capture, payload only
  always_ff @(posedge clk)
  begin
    if (state == cachePkg::CacheIdle && (cpuRe || cpuWe))
    begin
      reqAddr <= cpuAddr;
      reqWData <= cpuWData;
    end
  end

  // request kind and hit flag
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      reqWrite <= 1'b0;
      hitReg <= 1'b0;
    end
    else
    begin
      if (state == cachePkg::CacheIdle && (cpuRe || cpuWe))
        reqWrite <= cpuWe;
      // hit flag for reads and writes alike
      if (state == cachePkg::CacheLookup)
        hitReg <= lookupHit;
    end
  end

  // read data, from the line on a hit or the fetched block on a miss
  always_ff @(posedge clk)
  begin
    if (state == cachePkg::CacheLookup && !reqWrite && lookupHit)
      rData <= pickWord(lineBlock, reqOffset);
    else if (state == cachePkg::CacheReadMiss && mem.valid)
      rData <= pickWord(mem.rBlock, reqOffset);
  end

  // idle reads straight from the CPU address to save a cycle
  assign rdIndex = (state == cachePkg::CacheIdle) ?
                   cpuAddr[cachePkg::IndexLsb +: cachePkg::IndexBits] : reqIndex;

  // fill on the returning block of a read miss
  assign fillEn = (state == cachePkg::CacheReadMiss) && mem.valid;
  assign fillTag = reqTag;
  assign fillBlock = mem.rBlock;

  // cached copy follows memory on a write hit only
  assign wrEn = (state == cachePkg::CacheWriteThrough) && mem.valid && hitReg;
  assign wrOffset = reqOffset;
  assign wrWord = reqWData;

  // memory requests held for the whole state
  assign mem.re = (state == cachePkg::CacheReadMiss);
  assign mem.we = (state == cachePkg::CacheWriteThrough);
  assign mem.addr = reqAddr;
  assign mem.wData = reqWData;

  // CPU response
  assign cpuReady = (state == cachePkg::CacheRespond);
  assign cpuHit = hitReg;
  assign cpuRData = rData;

endmodule

//--- cache/cacheStore.sv
`timescale 1ns/1ps

// tag, valid and data arrays for a direct mapped cache
// one registered read port, one write port at the same index
module cacheStore (
  input logic clk,
  input logic arstN,
  input cachePkg::index_t rdIndex,
  input logic fillEn,
  input cachePkg::tag_t fillTag,
  input cachePkg::block_t fillBlock,
  input logic wrEn,
  input cachePkg::offset_t wrOffset,
  input cachePkg::word_t wrWord,
  output logic lineValid,
  output cachePkg::tag_t lineTag,
  output cachePkg::block_t lineBlock
);

  // per line valid flags
  logic [cachePkg::NumLines-1:0] validBits;

  // tag and data arrays
  cachePkg::tag_t tagArr [cachePkg::NumLines];
  cachePkg::block_t dataArr [cachePkg::NumLines];

  // bit position of the word being updated
  int wrLsb;

  // word 0 lives in the top slot, so flip the offset
  assign wrLsb = (cachePkg::BlockWords - 1 - int'(wrOffset)) * cachePkg::WordWidth;

  // valid bits
  // a fill marks its line, nothing ever invalidates
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      validBits <= '0;
      lineValid <= 1'b0;
    end
    else
    begin
      if (fillEn)
        validBits[rdIndex] <= 1'b1;
      // read sees the value from before this edge
      lineValid <= validBits[rdIndex];
    end
  end

  // tags and data
  always_ff @(posedge clk)
  begin
    if (fillEn)
    begin
      // whole line replaced on a miss
      tagArr[rdIndex] <= fillTag;
      dataArr[rdIndex] <= fillBlock;
    end
    else if (wrEn)
    begin
      // write hit, patch one word only
      dataArr[rdIndex][wrLsb +: cachePkg::WordWidth] <= wrWord;
    end

    // registered read of the addressed line
    lineTag <= tagArr[rdIndex];
    lineBlock <= dataArr[rdIndex];
  end

endmodule

//--- common/cachePkg.sv
package cachePkg;

  // data word and block geometry
  localparam int WordWidth = 32;
  localparam int BlockWords = 4;
  localparam int BlockWidth = WordWidth * BlockWords;

  // cache geometry, direct mapped
  localparam int NumLines = 16;

  // main memory depth in words
  localparam int MemWords = 4096;
  localparam int MemAddrBits = $clog2(MemWords);

  // memory wait states and the counter that tracks them
  localparam int MemWaitCycles = 2;
  localparam int MemCountBits = $clog2(MemWaitCycles) + 1;

  // byte address split: [13:8] tag, [7:4] index, [3:2] offset
  localparam int OffsetBits = $clog2(BlockWords);
  localparam int IndexBits = $clog2(NumLines);
  localparam int TagBits = 6;
  localparam int OffsetLsb = 2;
  localparam int IndexLsb = OffsetLsb + OffsetBits;
  localparam int TagLsb = IndexLsb + IndexBits;

  typedef logic [WordWidth-1:0] word_t;
  typedef logic [31:0] addr_t;
  // word 0 sits in the top 32 bits
  typedef logic [BlockWidth-1:0] block_t;
  typedef logic [TagBits-1:0] tag_t;
  typedef logic [IndexBits-1:0] index_t;
  typedef logic [OffsetBits-1:0] offset_t;

  // memory model sequencing
  typedef enum logic [1:0] {
    MemIdle,
    MemRequested,
    MemRetrieved
  } memState_t;

  // cache controller sequencing
  typedef enum logic [2:0] {
    CacheIdle,
    CacheLookup,
    CacheReadMiss,
    CacheWriteThrough,
    CacheRespond
  } cacheState_t;

endpackage

//--- common/memBusIf.sv
`timescale 1ns/1ps

// cache controller to main memory link
interface memBusIf;

  // request side, held until valid
  logic re;
  logic we;
  cachePkg::addr_t addr;
  cachePkg::word_t wData;

  // response side
  // aligned block around addr, good while valid is high
  cachePkg::block_t rBlock;
  // single cycle completion pulse
  logic valid;

  // cache controller view
  modport requester (
    output re, we, addr, wData,
    input rBlock, valid
  );

  // memory model view
  modport responder (
    input re, we, addr, wData,
    output rBlock, valid
  );

endinterface

//--- dv/memSystemChecker.sv
`timescale 1ns/1ps

// watches the CPU port and compares each response with the expected values
module memSystemChecker (
  input logic clk,
  input logic arstN,
  input logic cpuRe,
  input logic cpuWe,
  input cachePkg::addr_t cpuAddr,
  input cachePkg::word_t cpuRData,
  input logic cpuReady,
  input logic cpuHit,
  input cachePkg::word_t expRData,
  input logic expHit,
  input int testNum,
  input logic testDone,
  input logic runDone,
  output int checkCount,
  output int errorCount
);

  // read hits answer two edges after the strobe edge
  localparam int HitLatency = 2;

  int cycle;
  int startCycle;
  logic pending;
  logic pendWrite;
  cachePkg::addr_t pendAddr;
  int testChecks;
  int testErrors;
  int testsDone;

  function automatic string testName(input int n);
    case (n)
      1: return "reset state";
      2: return "write then read";
      3: return "read hit timing";
      4: return "write-through on hit";
      5: return "no write allocate";
      6: return "conflict eviction";
      default: return "unknown";
    endcase
  endfunction

  initial
  begin
    cycle = 0;
    startCycle = 0;
    pending = 1'b0;
    pendWrite = 1'b0;
    pendAddr = '0;
    testChecks = 0;
    testErrors = 0;
    testsDone = 0;
    checkCount = 0;
    errorCount = 0;
  end

  // values driven on the falling edge, so the rising edge sees them settled
  always @(posedge clk)
  begin
    logic bad;
    bad = 1'b0;
    cycle++;
    if (arstN && cpuReady)
    begin
      if (!pending)
      begin
        $display("cpuReady pulsed at %0t with no access outstanding", $time);
        bad = 1'b1;
      end
      else
      begin
        checkCount++;
        testChecks++;
        // data only means something on reads
        if (!pendWrite && cpuRData !== expRData)
        begin
          $display("Fail at %0t: read of %h returned %h, expected %h",
                   $time, pendAddr, cpuRData, expRData);
          bad = 1'b1;
        end
        if (cpuHit !== expHit)
        begin
          $display("Fail at %0t: %s of %h gave hit %0b, expected %0b",
                   $time, pendWrite ? "write" : "read", pendAddr, cpuHit, expHit);
          bad = 1'b1;
        end
        if (!pendWrite && expHit && (cycle - startCycle) != HitLatency)
        begin
          $display("Fail at %0t: read hit of %h took %0d cycles, expected %0d",
                   $time, pendAddr, cycle - startCycle, HitLatency);
          bad = 1'b1;
        end
      end
      pending = 1'b0;
    end
    if (bad)
    begin
      errorCount++;
      testErrors++;
    end
    // new access, one in flight at most
    if (arstN && (cpuRe || cpuWe))
    begin
      pending = 1'b1;
      pendWrite = cpuWe;
      pendAddr = cpuAddr;
      startCycle = cycle;
    end
    if (testDone)
    begin
      $display("test %0d (%s): %0d accesses, %0d errors",
               testNum, testName(testNum), testChecks, testErrors);
      testsDone++;
      testChecks = 0;
      testErrors = 0;
    end
    if (runDone)
      $display("summary: %0d tests, %0d accesses checked, %0d errors",
               testsDone, checkCount, errorCount);
  end

endmodule

//--- dv/memSystemTb.sv
`timescale 1ns/1ps

// testbench top for the cache and main memory subsystem
module memSystemTb;

  localparam int ResetCycles = 16;
  localparam int RandomOps = 40;
  // accesses per test, in order
  localparam int ResetOps = 64 + 16;
  localparam int RegionOps = 64 + 64;
  localparam int HitOps = 16;
  localparam int WriteHitOps = 4 * 4;
  localparam int NoAllocOps = 4 * 2;
  localparam int TotalOps = ResetOps + RegionOps + HitOps + WriteHitOps + NoAllocOps + RandomOps;
  // longest access plus the gap between accesses, then reset and slack
  localparam int TimeoutCycles =
    TotalOps * (2 + cachePkg::MemWaitCycles + 6) + ResetCycles + 200;
  // tags 1 and 2 are filled regions, tag 3 is left mostly unwritten
  localparam int TagA = 1;
  localparam int TagB = 2;
  localparam int TagC = 3;

  logic clk;
  logic arstN;
  logic cpuRe;
  logic cpuWe;
  cachePkg::addr_t cpuAddr;
  cachePkg::word_t cpuWData;
  cachePkg::word_t cpuRData;
  logic cpuReady;
  logic cpuHit;

  // expected response of the access in flight
  cachePkg::word_t expRData;
  logic expHit;
  int testNum;
  logic testDone;
  logic runDone;
  int checkCount;
  int errorCount;
  int cycleCount;

  // shadow of main memory and of the tag and valid table
  cachePkg::word_t shadowMem [4096];
  logic [15:0] shadowValid;
  logic [5:0] shadowTag [16];

  memSystemTop DUT (
    .clk(clk),
    .arstN(arstN),
    .cpuRe(cpuRe),
    .cpuWe(cpuWe),
    .cpuAddr(cpuAddr),
    .cpuWData(cpuWData),
    .cpuRData(cpuRData),
    .cpuReady(cpuReady),
    .cpuHit(cpuHit)
  );

  memSystemChecker scoreboard (
    .clk(clk),
    .arstN(arstN),
    .cpuRe(cpuRe),
    .cpuWe(cpuWe),
    .cpuAddr(cpuAddr),
    .cpuRData(cpuRData),
    .cpuReady(cpuReady),
    .cpuHit(cpuHit),
    .expRData(expRData),
    .expHit(expHit),
    .testNum(testNum),
    .testDone(testDone),
    .runDone(runDone),
    .checkCount(checkCount),
    .errorCount(errorCount)
  );

  // direct mapped, write-through, no allocate on write misses
  // tag [13:8], index [7:4], word in memory [13:2]
  function automatic void expectAccess(input logic isWrite, input cachePkg::addr_t addr,
                                       input cachePkg::word_t wData,
                                       output cachePkg::word_t expData, output logic hit);
    logic [3:0] idx;
    logic [5:0] tag;
    logic [11:0] wordIdx;
    idx = addr[7:4];
    tag = addr[13:8];
    wordIdx = addr[13:2];
    hit = shadowValid[idx] && (shadowTag[idx] == tag);
    if (isWrite)
    begin
      shadowMem[wordIdx] = wData;
      expData = wData;
    end
    else
    begin
      // read miss brings the block in
      if (!hit)
      begin
        shadowValid[idx] = 1'b1;
        shadowTag[idx] = tag;
      end
      expData = shadowMem[wordIdx];
    end
  endfunction

  function automatic cachePkg::addr_t makeAddr(input int tag, input int idx, input int off);
    return cachePkg::addr_t'({tag[5:0], idx[3:0], off[1:0], 2'b00});
  endfunction

  // one strobe, then wait for ready
  task automatic access(input logic isWrite, input cachePkg::addr_t addr,
                        input cachePkg::word_t data);
    cachePkg::word_t eData;
    logic eHit;
    @(negedge clk);
    expectAccess(isWrite, addr, data, eData, eHit);
    expRData = eData;
    expHit = eHit;
    cpuAddr = addr;
    cpuWData = data;
    cpuRe = !isWrite;
    cpuWe = isWrite;
    @(negedge clk);
    cpuRe = 1'b0;
    cpuWe = 1'b0;
    while (!cpuReady)
      @(negedge clk);
  endtask

  task automatic finishTest();
    @(negedge clk);
    testDone = 1'b1;
    @(negedge clk);
    testDone = 1'b0;
    testNum++;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    int idx;
    int tag;
    logic rw;
    void'($urandom(84));
    arstN = 1'b1;
    cpuRe = 1'b0;
    cpuWe = 1'b0;
    cpuAddr = '0;
    cpuWData = '0;
    expRData = '0;
    expHit = 1'b0;
    testNum = 1;
    testDone = 1'b0;
    runDone = 1'b0;
    shadowValid = '0;
    // drop reset after time zero so the falling edge is seen
    #1;
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    // writes never allocate, so every first read misses
    for (int i = 0; i < 16; i++)
      for (int w = 0; w < 4; w++)
        access(1'b1, makeAddr(TagA, i, w), $urandom());
    for (int i = 0; i < 16; i++)
      access(1'b0, makeAddr(TagA, i, 0), '0);
    finishTest();

    // second region evicts the first, one miss per block
    for (int i = 0; i < 16; i++)
      for (int w = 0; w < 4; w++)
        access(1'b1, makeAddr(TagB, i, w), $urandom());
    for (int i = 0; i < 16; i++)
      for (int w = 0; w < 4; w++)
        access(1'b0, makeAddr(TagB, i, w), '0);
    finishTest();

    // every line holds TagB now, latency checked on each hit
    for (int i = 0; i < 16; i++)
      access(1'b0, makeAddr(TagB, i, int'($urandom() % 4)), '0);
    finishTest();

    // write hit, read back, evict, then refetch from memory
    for (int k = 0; k < 4; k++)
    begin
      idx = k * 3;
      access(1'b1, makeAddr(TagB, idx, 1), $urandom());
      access(1'b0, makeAddr(TagB, idx, 1), '0);
      access(1'b0, makeAddr(TagA, idx, 2), '0);
      access(1'b0, makeAddr(TagB, idx, 1), '0);
    end
    finishTest();

    // write miss to an uncached block, next read still misses
    for (int i = 8; i < 12; i++)
    begin
      access(1'b1, makeAddr(TagC, i, 3), $urandom());
      access(1'b0, makeAddr(TagC, i, 3), '0);
    end
    finishTest();

    // two tags fighting over two lines
    for (int n = 0; n < RandomOps; n++)
    begin
      idx = ($urandom() % 2 == 0) ? 5 : 10;
      tag = ($urandom() % 2 == 0) ? TagA : TagB;
      rw = ($urandom() % 2) == 1;
      access(rw, makeAddr(tag, idx, int'($urandom() % 4)), $urandom());
    end
    finishTest();

    @(negedge clk);
    runDone = 1'b1;
    @(negedge clk);
    runDone = 1'b0;
    @(negedge clk);
    if (checkCount != TotalOps)
      $display("only %0d of %0d accesses were answered", checkCount, TotalOps);
    if (errorCount == 0 && checkCount == TotalOps)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog on the whole run
  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("run timed out after %0d cycles before every access completed", cycleCount);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- dv/memSystem_sva.sv
`timescale 1ns/1ps

// protocol and reset rules on the CPU port and the memory bus
module memSystemSva (
  input logic clk,
  input logic arstN,
  input logic cpuReady,
  input logic re,
  input logic we,
  input logic valid
);

  // ready is a single cycle pulse
  readyOneCycle: assert property (@(posedge clk) disable iff (!arstN) cpuReady |=> !cpuReady)
    else $error("cpuReady stayed high for more than one cycle");

  // one kind of memory request at a time
  oneRequestKind: assert property (@(posedge clk) disable iff (!arstN) !(re && we))
    else $error("re and we both high on the memory bus");

  // memory only answers a held request
  validNeedsRequest: assert property (@(posedge clk) disable iff (!arstN) valid |-> (re || we))
    else $error("valid high with no memory request");

  // nothing completes while reset is held
  readyLowInReset: assert property (@(posedge clk) !arstN |-> !cpuReady)
    else $error("cpuReady high during reset");

endmodule

bind memSystemTop memSystemSva sva (
  .clk(clk),
  .arstN(arstN),
  .cpuReady(cpuReady),
  .re(memBus.re),
  .we(memBus.we),
  .valid(memBus.valid)
);

//--- hdl/memSystemTop.sv
`timescale 1ns/1ps

// cache plus main memory behind a plain CPU port
module memSystemTop (
  input logic clk,
  input logic arstN,
  input logic cpuRe,
  input logic cpuWe,
  input cachePkg::addr_t cpuAddr,
  input cachePkg::word_t cpuWData,
  output cachePkg::word_t cpuRData,
  output logic cpuReady,
  output logic cpuHit
);

  // controller to store
  cachePkg::index_t rdIndex;
  logic fillEn;
  cachePkg::tag_t fillTag;
  cachePkg::block_t fillBlock;
  logic wrEn;
  cachePkg::offset_t wrOffset;
  cachePkg::word_t wrWord;

  // store back to controller
  logic lineValid;
  cachePkg::tag_t lineTag;
  cachePkg::block_t lineBlock;

  // controller to memory
  memBusIf memBus ();

  cacheController cacheCtrl (
    .clk(clk),
    .arstN(arstN),
    .cpuRe(cpuRe),
    .cpuWe(cpuWe),
    .cpuAddr(cpuAddr),
    .cpuWData(cpuWData),
    .cpuRData(cpuRData),
    .cpuReady(cpuReady),
    .cpuHit(cpuHit),
    .rdIndex(rdIndex),
    .fillEn(fillEn),
    .fillTag(fillTag),
    .fillBlock(fillBlock),
    .wrEn(wrEn),
    .wrOffset(wrOffset),
    .wrWord(wrWord),
    .lineValid(lineValid),
    .lineTag(lineTag),
    .lineBlock(lineBlock),
    .mem(memBus.requester)
  );

  cacheStore store (
    .clk(clk),
    .arstN(arstN),
    .rdIndex(rdIndex),
    .fillEn(fillEn),
    .fillTag(fillTag),
    .fillBlock(fillBlock),
    .wrEn(wrEn),
    .wrOffset(wrOffset),
    .wrWord(wrWord),
    .lineValid(lineValid),
    .lineTag(lineTag),
    .lineBlock(lineBlock)
  );

  mainMemory mainMem (
    .clk(clk),
    .arstN(arstN),
    .mem(memBus.responder)
  );

endmodule

//--- mainMemory/mainMemory.sv
`timescale 1ns/1ps

// slow main memory with fixed wait states
// reads return a whole block, writes touch one word
module mainMemory (
  input logic clk,
  input logic arstN,
  memBusIf.responder mem
);

  cachePkg::memState_t state;
  cachePkg::memState_t nextState;
  logic [cachePkg::MemCountBits-1:0] waitCount;

  // storage, no reset and no preload
  cachePkg::word_t ram [cachePkg::MemWords];

  // word address from the byte address, high bits dropped
  logic [cachePkg::MemAddrBits-1:0] wordAddr;
  cachePkg::block_t blockOut;

  // state register
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      state <= cachePkg::MemIdle;
    else
      state <= nextState;
  end

  // next state
  always_comb
  begin
    nextState = state;
    case (state)
      cachePkg::MemIdle:
      begin
        // either request kicks off a wait
        if (mem.re || mem.we)
          nextState = cachePkg::MemRequested;
      end
      cachePkg::MemRequested:
      begin
        if (waitCount >= cachePkg::MemCountBits'(cachePkg::MemWaitCycles))
          nextState = cachePkg::MemRetrieved;
      end
      cachePkg::MemRetrieved:
        nextState = cachePkg::MemIdle;
      default:
        nextState = cachePkg::MemIdle;
    endcase
  end

  // wait counter
  // cleared while idle, counts while requested, holds in retrieved
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      waitCount <= '0;
    else if (state == cachePkg::MemIdle)
      waitCount <= '0;
    else if (state == cachePkg::MemRequested)
      waitCount <= waitCount + 1'b1;
  end

  assign mem.valid = (state == cachePkg::MemRetrieved);

  assign wordAddr = mem.addr[cachePkg::OffsetLsb +: cachePkg::MemAddrBits];

  // gather the aligned block, word 0 on top
  always_comb
  begin
    for (int w = 0; w < cachePkg::BlockWords; w++)
    begin
      blockOut[(cachePkg::BlockWords - 1 - w) * cachePkg::WordWidth +: cachePkg::WordWidth] =
        ram[{wordAddr[cachePkg::MemAddrBits-1:cachePkg::OffsetBits], cachePkg::offset_t'(w)}];
    end
  end

  assign mem.rBlock = blockOut;

  // single word write, repeats harmlessly while we is held
  always_ff @(posedge clk)
  begin
    if (mem.we)
      ram[wordAddr] <= mem.wData;
  end

endmodule

//--- project.f
common/cachePkg.sv
common/memBusIf.sv
mainMemory/mainMemory.sv
cache/cacheStore.sv
cache/cacheController.sv
hdl/memSystemTop.sv
dv/memSystem_sva.sv
dv/memSystemChecker.sv
dv/memSystemTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module memSystemTb -o memSystemSim || { echo "build failed"; exit 1; }
./obj_dir/memSystemSim > sim.log 2>&1
cat sim.log
grep -qx "ALL TESTS PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
